/* sim.f */
+incdir+verification
common/video_pkg.sv
common/raster_pkg.sv
rtx/rtx_engine.sv
frame_buffer/frame_store.sv
logic/video_timing.sv
logic/display_combiner.sv
logic/rtx_display_top.sv
verification/tb_rtx_display.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with verilator, result taken from the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_rtx_display -f sim.f -o tb_rtx_display

./obj_dir/tb_rtx_display | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation finished without failures"

/* verification/tb_display_model.svh */
`ifndef TB_DISPLAY_MODEL_SVH
`define TB_DISPLAY_MODEL_SVH

// reference model of the render and display path, stepped once per clock
// state here always stands for the DUT registers after the latest rising edge

localparam int FULL_COLS = H_ACT >> FULL_SH;
localparam int PK_COLS   = H_ACT >> PK_SH;

typedef struct packed {
  logic        act;     // levels decoded from the display counts
  logic        hs;
  logic        vs;
  logic        full_ok; // word had been written when it was read
  logic [23:0] full_w;  // {blue, green, red}
  logic        pk_ok;
  logic [23:0] pk_w;
} stage_t;

int          m_wait = 0;     // engine divider
int          m_h = 0;        // engine raster position
int          m_v = 0;
int          m_frame = 0;
int          m_hc = 0;       // display counts
int          m_vc = 0;
int          quiet_cnt = 2;  // checks still due inside the reset window
logic [23:0] full_mem [int]; // mirror of the full-colour store, by word address
logic [23:0] pk_mem [int];   // mirror of the packed store, already truncated
stage_t      stg = '0;       // store read stage
logic        exp_act = 1'b0; // output register stage
logic        exp_hs = 1'b0;
logic        exp_vs = 1'b0;
logic        exp_ok = 1'b0;
logic        exp_src = 1'b0;
logic [23:0] exp_col = '0;

// test pattern: red full, green bar steps with frame, blue with the top frame bits
function automatic logic [23:0] shade(input int h, input int v, input int f);
  logic [7:0] g;
  logic [7:0] b;
  g = (f[2:0] > h[7:5]) ? 8'hff : 8'h00;
  b = (f[7:5] > v[6:4]) ? 8'hff : 8'h00;
  return {b, g, 8'hff};
endfunction

// 5/6/5 copy keeps the top bits only, low bits read back as zero
function automatic logic [23:0] drop_low_bits(input logic [23:0] c);
  return c & 24'hf8fcf8;
endfunction

task automatic model_step();
  logic [23:0] col;
  logic        valid;
  logic        in_pic;
  int          fa;
  int          pa;
  valid  = (m_wait == 0);
  col    = shade(m_h, m_v, m_frame);
  in_pic = (m_hc < H_ACT) && (m_vc < V_ACT);
  if (sys_rst) begin
    exp_act = 1'b0;
    exp_hs  = 1'b0;
    exp_vs  = 1'b0;
    exp_col = '0;
  end else begin
    exp_act = stg.act;
    exp_hs  = stg.hs;
    exp_vs  = stg.vs;
    exp_src = src_sel; // select is taken live at the output register
    exp_ok  = src_sel ? stg.pk_ok : stg.full_ok;
    exp_col = !stg.act ? 24'h0 : (src_sel ? stg.pk_w : stg.full_w);
  end
  stg.act = !sys_rst && in_pic;
  stg.hs  = !sys_rst && (m_hc >= HS_START) && (m_hc < HS_START + HS_LEN);
  stg.vs  = !sys_rst && (m_vc >= VS_START) && (m_vc < VS_START + VS_LEN);
  // reads see the mirrors before this edge's write
  fa = (m_vc >> FULL_SH) * FULL_COLS + (m_hc >> FULL_SH);
  pa = (m_vc >> PK_SH) * PK_COLS + (m_hc >> PK_SH);
  stg.full_ok = in_pic && (full_mem.exists(fa) != 0);
  stg.full_w  = stg.full_ok ? full_mem[fa] : 24'h0;
  stg.pk_ok   = in_pic && (pk_mem.exists(pa) != 0);
  stg.pk_w    = stg.pk_ok ? pk_mem[pa] : 24'h0;
  if (valid) begin // strobe writes both copies, last write wins
    fa = (m_v >> FULL_SH) * FULL_COLS + (m_h >> FULL_SH);
    pa = (m_v >> PK_SH) * PK_COLS + (m_h >> PK_SH);
    full_mem[fa] = col;
    pk_mem[pa]   = drop_low_bits(col);
  end
  if (sys_rst) begin
    m_wait    = 0;
    m_h       = 0;
    m_v       = 0;
    m_frame   = 0;
    m_hc      = 0;
    m_vc      = 0;
    quiet_cnt = 2; // two more quiet cycles follow the last reset edge
  end else begin
    if (valid && m_h == H_ACT - 1) begin
      m_h = 0;
      if (m_v == V_ACT - 1) begin
        m_v     = 0;
        m_frame = (m_frame + 1) % 256; // frame wrap
      end else begin
        m_v++;
      end
    end else if (valid) begin
      m_h++;
    end
    m_wait = (m_wait + 1) % (1 << WAIT_B);
    if (m_hc == H_TOT - 1) begin
      m_hc = 0;
      m_vc = (m_vc == V_TOT - 1) ? 0 : m_vc + 1;
    end else begin
      m_hc++;
    end
    if (quiet_cnt > 0) quiet_cnt--;
  end
endtask

`endif

/* verification/tb_rtx_display.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rtx_display;

  import raster_pkg::*;
  import video_pkg::*;

  localparam int H_ACT      = 16;  // small raster so a frame takes 512 cycles
  localparam int V_ACT      = 8;
  localparam int H_TOT      = 20;
  localparam int V_TOT      = 10;
  localparam int HS_START   = 17;
  localparam int HS_LEN     = 2;
  localparam int VS_START   = 8;
  localparam int VS_LEN     = 1;
  localparam int WAIT_B     = 2;   // one strobe every 4 cycles
  localparam int FULL_SH    = 1;
  localparam int PK_SH      = 0;
  localparam int RST_CYCLES = 10;
  localparam int RUN_FRAMES = 3;
  localparam int RUN_LIMIT  = 4000; // cycles allowed for the whole run

  logic       clk_rtx;
  logic       sys_rst;
  logic       src_sel;
  logic       rtx_valid;
  h_coord_t   rtx_h;
  v_coord_t   rtx_v;
  rgb888_t    rtx_color;
  frame_cnt_t frame_count;
  logic [7:0] red;
  logic [7:0] green;
  logic [7:0] blue;
  logic       h_sync_out;
  logic       v_sync_out;
  logic       active_out;

  int seed;
  int err_pace = 0;
  int err_shade = 0;
  int err_timing = 0;
  int err_full = 0;
  int err_packed = 0;
  int err_reset = 0;

  `include "tb_display_model.svh"

  rtx_display_top #(
    .H_ACTIVE    (H_ACT),
    .V_ACTIVE    (V_ACT),
    .WAIT_BITS   (WAIT_B),
    .H_TOTAL     (H_TOT),
    .V_TOTAL     (V_TOT),
    .H_SYNC_START(HS_START),
    .H_SYNC_LEN  (HS_LEN),
    .V_SYNC_START(VS_START),
    .V_SYNC_LEN  (VS_LEN),
    .FULL_SHIFT  (FULL_SH),
    .PACKED_SHIFT(PK_SH)
  ) i_rtx_display_top (
    .clk_rtx    (clk_rtx),
    .sys_rst    (sys_rst),
    .src_sel    (src_sel),
    .rtx_valid  (rtx_valid),
    .rtx_h      (rtx_h),
    .rtx_v      (rtx_v),
    .rtx_color  (rtx_color),
    .frame_count(frame_count),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .h_sync_out (h_sync_out),
    .v_sync_out (v_sync_out),
    .active_out (active_out)
  );

  initial begin
    clk_rtx = 1'b0;
    forever #4 clk_rtx = ~clk_rtx; // 8 ns period
  end

  // compares DUT outputs with the model state for the same edge
  task automatic check_outputs();
    logic [23:0] dut_col;
    dut_col = {blue, green, red};
    assert (rtx_valid === (m_wait == 0)) else begin
      $display("Error scan_pacing: expected valid %0b, actual %0b", m_wait == 0, rtx_valid);
      err_pace++;
    end
    assert (rtx_h === 11'(m_h) && rtx_v === 10'(m_v) && frame_count === 8'(m_frame)) else begin
      $display("Error scan_order: expected h %0d v %0d f %0d, actual h %0d v %0d f %0d",
               m_h, m_v, m_frame, rtx_h, rtx_v, frame_count);
      err_pace++;
    end
    if (m_wait == 0) begin // colour only matters on a strobe
      assert (rtx_color === shade(m_h, m_v, m_frame)) else begin
        $display("Error shading: expected %h, actual %h", shade(m_h, m_v, m_frame), rtx_color);
        err_shade++;
      end
    end
    assert ({h_sync_out, v_sync_out, active_out} === {exp_hs, exp_vs, exp_act}) else begin
      $display("Error display_timing: expected hs/vs/act %b, actual %b",
               {exp_hs, exp_vs, exp_act}, {h_sync_out, v_sync_out, active_out});
      err_timing++;
    end
    if (!exp_act || exp_ok) begin // unwritten words are skipped
      assert (dut_col === exp_col) else begin
        $display("Error %s: expected %h, actual %h",
                 exp_src ? "packed_path" : "full_path", exp_col, dut_col);
        if (exp_src) err_packed++;
        else err_full++;
      end
    end
    if (quiet_cnt > 0) begin
      assert ({h_sync_out, v_sync_out, active_out, dut_col} === '0) else begin
        $display("Error reset_quiet: expected 0, actual %h",
                 {h_sync_out, v_sync_out, active_out, dut_col});
        err_reset++;
      end
    end
  endtask

  // DUT outputs have settled by the falling edge
  // checking starts after the first rising edge
  initial begin
    @(posedge clk_rtx);
    forever begin
      @(negedge clk_rtx);
      check_outputs();
      model_step();
    end
  end

  initial begin
    int waited;
    int line_cyc;
    int rnd;
    int total;
    bit timed_out;
    sys_rst   = 1'b1;
    src_sel   = 1'b0;
    seed      = 68;
    waited    = 0;
    line_cyc  = 0;
    timed_out = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_rtx);
    #1;
    sys_rst = 1'b0;
    // run until three frames are rendered or the cycle limit runs out
    while (frame_count !== 8'(RUN_FRAMES) && !timed_out) begin
      @(posedge clk_rtx);
      #1;
      line_cyc++;
      if (line_cyc == H_TOT) begin // new select once per display line
        line_cyc = 0;
        rnd      = $random(seed);
        src_sel  = rnd[0];
      end
      waited++;
      if (waited > RUN_LIMIT) timed_out = 1'b1;
    end
    if (timed_out) $display("timeout: frame_count did not reach %0d in time", RUN_FRAMES);
    total = err_pace + err_shade + err_timing + err_full + err_packed + err_reset;
    $display("errors: pacing %0d shading %0d timing %0d full %0d packed %0d reset %0d",
             err_pace, err_shade, err_timing, err_full, err_packed, err_reset);
    if (total == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* logic/rtx_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

// render-to-display path on a single clock
// engine -> two frame stores -> combiner, paced on the read side by video_timing
module rtx_display_top #(
  parameter int H_ACTIVE     = 1280,
  parameter int V_ACTIVE     = 720,
  parameter int WAIT_BITS    = 8,
  parameter int H_TOTAL      = 1650,
  parameter int V_TOTAL      = 750,
  parameter int H_SYNC_START = 1390,
  parameter int H_SYNC_LEN   = 40,
  parameter int V_SYNC_START = 725,
  parameter int V_SYNC_LEN   = 5,
  parameter int FULL_SHIFT   = 2,  // bram copy at quarter size each way
  parameter int PACKED_SHIFT = 0   // dram copy at full size
) (
  input  logic                   clk_rtx,
  input  logic                   sys_rst,
  input  logic                   src_sel,
  output logic                   rtx_valid,
  output raster_pkg::h_coord_t   rtx_h,
  output raster_pkg::v_coord_t   rtx_v,
  output video_pkg::rgb888_t     rtx_color,
  output raster_pkg::frame_cnt_t frame_count,
  output logic [7:0]             red,
  output logic [7:0]             green,
  output logic [7:0]             blue,
  output logic                   h_sync_out,
  output logic                   v_sync_out,
  output logic                   active_out
);

  import raster_pkg::*;
  import video_pkg::*;

  h_coord_t h_count;      // display raster position
  v_coord_t v_count;
  logic     h_sync;
  logic     v_sync;
  logic     active_draw;
  rgb888_t  full_pixel;   // read data, one cycle behind the counts
  rgb565_t  packed_pixel;

  rtx_engine #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .WAIT_BITS(WAIT_BITS)
  ) i_rtx_engine (
    .clk_rtx    (clk_rtx),
    .sys_rst    (sys_rst),
    .rtx_valid  (rtx_valid),
    .rtx_h      (rtx_h),
    .rtx_v      (rtx_v),
    .rtx_color  (rtx_color),
    .frame_count(frame_count)
  );

  frame_store #(
    .pixel_t (rgb888_t),
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE),
    .SHIFT   (FULL_SHIFT)
  ) full_store (
    .clk_rtx (clk_rtx),
    .wr_en   (rtx_valid),
    .wr_h    (rtx_h),
    .wr_v    (rtx_v),
    .wr_pixel(rtx_color),
    .rd_h    (h_count),
    .rd_v    (v_count),
    .rd_pixel(full_pixel)
  );

  frame_store #(
    .pixel_t (rgb565_t),
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE),
    .SHIFT   (PACKED_SHIFT)
  ) packed_store (
    .clk_rtx (clk_rtx),
    .wr_en   (rtx_valid),
    .wr_h    (rtx_h),
    .wr_v    (rtx_v),
    .wr_pixel(pack_565(rtx_color)), // 565 packing on the way in, as the dram path does
    .rd_h    (h_count),
    .rd_v    (v_count),
    .rd_pixel(packed_pixel)
  );

  video_timing #(
    .H_ACTIVE    (H_ACTIVE),
    .V_ACTIVE    (V_ACTIVE),
    .H_TOTAL     (H_TOTAL),
    .V_TOTAL     (V_TOTAL),
    .H_SYNC_START(H_SYNC_START),
    .H_SYNC_LEN  (H_SYNC_LEN),
    .V_SYNC_START(V_SYNC_START),
    .V_SYNC_LEN  (V_SYNC_LEN)
  ) i_video_timing (
    .clk_rtx    (clk_rtx),
    .sys_rst    (sys_rst),
    .h_count    (h_count),
    .v_count    (v_count),
    .h_sync     (h_sync),
    .v_sync     (v_sync),
    .active_draw(active_draw)
  );

  display_combiner i_display_combiner (
    .clk_rtx     (clk_rtx),
    .sys_rst     (sys_rst),
    .src_sel     (src_sel),
    .full_pixel  (full_pixel),
    .packed_pixel(packed_pixel),
    .h_sync      (h_sync),
    .v_sync      (v_sync),
    .active_draw (active_draw),
    .red         (red),
    .green       (green),
    .blue        (blue),
    .h_sync_out  (h_sync_out),
    .v_sync_out  (v_sync_out),
    .active_out  (active_out)
  );

endmodule

`default_nettype wire

/* logic/display_combiner.sv */
`timescale 1ns/1ps
`default_nettype none

// picks one frame store, widens the packed word, blanks, registers the outputs
// stage 1 holds the control levels while the stores read
// stage 2 is the output register
module display_combiner (
  input  logic                  clk_rtx,
  input  logic                  sys_rst,
  input  logic                  src_sel,       // 0 full-colour store, 1 packed store
  input  video_pkg::rgb888_t    full_pixel,
  input  video_pkg::rgb565_t    packed_pixel,
  input  logic                  h_sync,
  input  logic                  v_sync,
  input  logic                  active_draw,
  output logic [7:0]            red,
  output logic [7:0]            green,
  output logic [7:0]            blue,
  output logic                  h_sync_out,
  output logic                  v_sync_out,
  output logic                  active_out
);

  import video_pkg::*;

  logic    h_sync_d;   // aligned with rd_pixel from the stores
  logic    v_sync_d;
  logic    active_d;
  rgb888_t pick;       // chosen source, already 24 bits

  // src_sel is used live here, together with the store data
  assign pick = src_sel ? widen_565(packed_pixel) : full_pixel;

  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      h_sync_d   <= 1'b0;
      v_sync_d   <= 1'b0;
      active_d   <= 1'b0;
      h_sync_out <= 1'b0;
      v_sync_out <= 1'b0;
      active_out <= 1'b0;
      red        <= '0;
      green      <= '0;
      blue       <= '0;
    end else begin
      h_sync_d   <= h_sync;
      v_sync_d   <= v_sync;
      active_d   <= active_draw;
      h_sync_out <= h_sync_d;
      v_sync_out <= v_sync_d;
      active_out <= active_d;
      red        <= active_d ? pick.red   : 8'h00; // black outside the picture
      green      <= active_d ? pick.green : 8'h00;
      blue       <= active_d ? pick.blue  : 8'h00;
    end
  end

endmodule

`default_nettype wire

/* logic/video_timing.sv */
`timescale 1ns/1ps
`default_nettype none

// display raster generator, one display pixel per clk_rtx cycle
// syncs and active level decode straight from the current counts
module video_timing #(
  parameter int H_ACTIVE     = 1280,
  parameter int V_ACTIVE     = 720,
  parameter int H_TOTAL      = 1650,
  parameter int V_TOTAL      = 750,
  parameter int H_SYNC_START = 1390,
  parameter int H_SYNC_LEN   = 40,
  parameter int V_SYNC_START = 725,
  parameter int V_SYNC_LEN   = 5
) (
  input  logic                 clk_rtx,
  input  logic                 sys_rst,
  output raster_pkg::h_coord_t h_count,
  output raster_pkg::v_coord_t v_count,
  output logic                 h_sync,      // high during the sync pulse
  output logic                 v_sync,
  output logic                 active_draw  // inside the visible area
);

  import raster_pkg::*;

  localparam h_coord_t H_LAST     = h_coord_t'(H_TOTAL - 1);
  localparam v_coord_t V_LAST     = v_coord_t'(V_TOTAL - 1);
  localparam int       H_SYNC_END = H_SYNC_START + H_SYNC_LEN; // first count past pulse
  localparam int       V_SYNC_END = V_SYNC_START + V_SYNC_LEN;

  logic line_end;
  logic frame_end;

  assign line_end  = (h_count == H_LAST);
  assign frame_end = (v_count == V_LAST);

  // raster counters
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      h_count <= '0;
      v_count <= '0;
    end else if (line_end) begin
      h_count <= '0;
      v_count <= frame_end ? '0 : v_count + 1'b1; // next line or back to top
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  // decodes
  always_comb begin
    active_draw = (int'(h_count) < H_ACTIVE) && (int'(v_count) < V_ACTIVE);
    h_sync      = (int'(h_count) >= H_SYNC_START) && (int'(h_count) < H_SYNC_END);
    v_sync      = (int'(v_count) >= V_SYNC_START) && (int'(v_count) < V_SYNC_END);
  end

endmodule

`default_nettype wire

/* frame_buffer/frame_store.sv */
`timescale 1ns/1ps
`default_nettype none

// pixel memory for one copy of the rendered frame
// one write port from the engine, one registered read port for the display
// both sides are down-scaled by 2**SHIFT in each direction
module frame_store #(
  parameter type pixel_t  = logic [23:0],
  parameter int  H_ACTIVE = 1280,
  parameter int  V_ACTIVE = 720,
  parameter int  SHIFT    = 0
) (
  input  logic                 clk_rtx,
  input  logic                 wr_en,
  input  raster_pkg::h_coord_t wr_h,
  input  raster_pkg::v_coord_t wr_v,
  input  pixel_t               wr_pixel,
  input  raster_pkg::h_coord_t rd_h,
  input  raster_pkg::v_coord_t rd_v,
  output pixel_t               rd_pixel   // one cycle after rd_h/rd_v
);

  localparam int unsigned COLS   = H_ACTIVE >> SHIFT;
  localparam int unsigned ROWS   = V_ACTIVE >> SHIFT;
  localparam int unsigned DEPTH  = COLS * ROWS;
  localparam int unsigned ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  pixel_t mem [DEPTH]; // no reset, contents valid only once written

  logic [31:0] wr_lin; // full-width linear addresses
  logic [31:0] rd_lin;
  logic        wr_hit; // address lands inside the stored area
  logic        rd_hit;

  // row-major address from the scaled coordinates
  always_comb begin
    wr_lin = (32'(wr_v) >> SHIFT) * COLS + (32'(wr_h) >> SHIFT);
    rd_lin = (32'(rd_v) >> SHIFT) * COLS + (32'(rd_h) >> SHIFT);
    wr_hit = (wr_lin < DEPTH);
    rd_hit = (rd_lin < DEPTH);
  end

  // write side
  // several render pixels fold onto one word when SHIFT > 0, last one wins
  always_ff @(posedge clk_rtx) begin
    if (wr_en && wr_hit) begin
      mem[wr_lin[ADDR_W-1:0]] <= wr_pixel;
    end
  end

  // read side, nonblocking so a same-cycle write is not seen yet
  // in blanking the display counts run past the store, keep the last word then
  always_ff @(posedge clk_rtx) begin
    if (rd_hit) begin
      rd_pixel <= mem[rd_lin[ADDR_W-1:0]];
    end
  end

endmodule

`default_nettype wire

/* rtx/rtx_engine.sv */
`timescale 1ns/1ps
`default_nettype none

// stand-in render engine
// scans the active raster one pixel per strobe and shades it with a test pattern
module rtx_engine #(
  parameter int H_ACTIVE  = 1280,
  parameter int V_ACTIVE  = 720,
  parameter int WAIT_BITS = 8     // one pixel every 2**WAIT_BITS cycles
) (
  input  logic                   clk_rtx,
  input  logic                   sys_rst,
  output logic                   rtx_valid,   // pixel strobe
  output raster_pkg::h_coord_t   rtx_h,
  output raster_pkg::v_coord_t   rtx_v,
  output video_pkg::rgb888_t     rtx_color,   // shade of the current pixel
  output raster_pkg::frame_cnt_t frame_count  // rendered frames so far
);

  import raster_pkg::*;

  localparam h_coord_t H_LAST = h_coord_t'(H_ACTIVE - 1);
  localparam v_coord_t V_LAST = v_coord_t'(V_ACTIVE - 1);

  logic [WAIT_BITS-1:0] wait_cnt; // free-running pacing divider
  logic                 h_last;
  logic                 v_last;

  assign rtx_valid = (wait_cnt == '0); // strobe on divider zero
  assign h_last    = (rtx_h == H_LAST);
  assign v_last    = (rtx_v == V_LAST);

  // pacing divider, starts at zero so the first cycle out of reset strobes
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1; // wraps on its own
    end
  end

  // raster scan, one step per strobe
  always_ff @(posedge clk_rtx) begin
    if (sys_rst) begin
      rtx_h       <= '0;
      rtx_v       <= '0;
      frame_count <= '0;
    end else if (rtx_valid) begin
      if (h_last) begin
        rtx_h <= '0;
        if (v_last) begin
          rtx_v       <= '0;
          frame_count <= frame_count + 1'b1; // frame done
        end else begin
          rtx_v <= rtx_v + 1'b1;
        end
      end else begin
        rtx_h <= rtx_h + 1'b1;
      end
    end
  end

  // pattern shader
  // red is held at full scale
  // green is a pwm bar 32 columns wide, stepping with the frame count
  // blue is a slower pwm over 16-line bands, driven by the top frame bits
  always_comb begin
    rtx_color.red   = 8'hff;
    rtx_color.green = (frame_count[2:0] > rtx_h[7:5]) ? 8'hff : 8'h00;
    rtx_color.blue  = (frame_count[7:5] > rtx_v[6:4]) ? 8'hff : 8'h00;
  end

endmodule

`default_nettype wire

/* common/raster_pkg.sv */
`default_nettype none

package raster_pkg;

  localparam int H_COORD_W = 11; // enough for 1650 total columns
  localparam int V_COORD_W = 10; // enough for 750 total lines
  localparam int FRAME_W   = 8;

  // horizontal position, render side and display side alike
  typedef logic [H_COORD_W-1:0] h_coord_t;

  // vertical position
  typedef logic [V_COORD_W-1:0] v_coord_t;

  // rendered frame counter, wraps freely
  typedef logic [FRAME_W-1:0] frame_cnt_t;

endpackage

`default_nettype wire

/* common/video_pkg.sv */
`default_nettype none

package video_pkg;

  // full colour word, blue in the high byte and red in the low byte
  typedef struct packed {
    logic [7:0] blue;
    logic [7:0] green;
    logic [7:0] red;
  } rgb888_t;

  // packed word as kept on the dram path
  typedef struct packed {
    logic [4:0] blue;  // [15:11]
    logic [5:0] green; // [10:5]
    logic [4:0] red;   // [4:0]
  } rgb565_t;

  // keeps the top 5/6/5 bits of each channel
  function automatic rgb565_t pack_565(input rgb888_t c);
    return '{blue: c.blue[7:3], green: c.green[7:2], red: c.red[7:3]};
  endfunction

  // low bits come back as zero, no rounding
  function automatic rgb888_t widen_565(input rgb565_t p);
    return '{
      blue:  {p.blue, 3'b000},
      green: {p.green, 2'b00},
      red:   {p.red, 3'b000}
    };
  endfunction

endpackage

`default_nettype wire
